// File: vlog.f
+incdir+common
common/seg16_pkg.sv
common/disp_ctrl_if.sv
src/seg16_axil_regs.sv
seg16/seg16_glyph_rom.sv
seg16/seg16_scanner.sv
src/seg16_top.sv
test/tb_seg16.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, judge the result from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
	--top-module tb_seg16 -Mdir obj_dir -o tb_seg16 > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_seg16 > sim.log 2>&1 || echo "simulator exited with an error"

grep -q "SIMULATION FAILED" sim.log && { echo "testbench reported a failure, see sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "run ended without a result, see sim.log"; exit 1; }
echo "simulation clean, see sim.log"

// File: test/tb_seg16.sv
/* testbench for the sixteen-segment controller with AXI4-Lite tasks, reference glyphs,
   scan checker, cycle timeout and summary */
`timescale 1ns/1ps
`default_nettype none
`include "seg16_consts.svh"

module tb_seg16
	import seg16_pkg::*;
();

	localparam int SLOT_CYC    = 1 << `SEG16_SCAN_DIV_BITS;
	localparam int FRAME_CYC   = 16 * SLOT_CYC;
	localparam int STEP_CYC    = `SEG16_FRAMES_PER_STEP * FRAME_CYC;
	localparam int REG_ROUNDS  = 12;
	localparam int COUNT_STEPS = 20;
	// two frames per character, 24 count steps, register traffic
	localparam int TIMEOUT_CYC = 16 * 2 * FRAME_CYC + 24 * STEP_CYC + 2000;

	localparam logic [`SEG16_ADDR_W-1:0] ADDR_CTRL   = `SEG16_ADDR_W'(`SEG16_ADDR_CTRL);
	localparam logic [`SEG16_ADDR_W-1:0] ADDR_CHAR   = `SEG16_ADDR_W'(`SEG16_ADDR_CHAR);
	localparam logic [`SEG16_ADDR_W-1:0] ADDR_STATUS = `SEG16_ADDR_W'(`SEG16_ADDR_STATUS);
	localparam logic [`SEG16_ADDR_W-1:0] ADDR_BAD    = `SEG16_ADDR_W'(12); // unmapped

	// one-hot segment bits with a in bit 15
	localparam glyph_t SEG_A = 16'h8000;
	localparam glyph_t SEG_B = 16'h4000;
	localparam glyph_t SEG_C = 16'h2000;
	localparam glyph_t SEG_D = 16'h1000;
	localparam glyph_t SEG_E = 16'h0800;
	localparam glyph_t SEG_F = 16'h0400;
	localparam glyph_t SEG_G = 16'h0200;
	localparam glyph_t SEG_H = 16'h0100;
	localparam glyph_t SEG_U = 16'h0010; // left half of the middle bar
	localparam glyph_t SEG_P = 16'h0008; // right half of the middle bar

	logic                       CLK;
	logic                       reset;
	logic [`SEG16_ADDR_W-1:0]   awaddr;
	logic                       awvalid;
	logic                       awready;
	logic [`SEG16_DATA_W-1:0]   wdata;
	logic [`SEG16_DATA_W/8-1:0] wstrb;
	logic                       wvalid;
	logic                       wready;
	logic [1:0]                 bresp;
	logic                       bvalid;
	logic                       bready;
	logic [`SEG16_ADDR_W-1:0]   araddr;
	logic                       arvalid;
	logic                       arready;
	logic [`SEG16_DATA_W-1:0]   rdata;
	logic [1:0]                 rresp;
	logic                       rvalid;
	logic                       rready;
	logic [15:0]                seg_n;
	logic                       frame_mark;

	int         seed = 32'h1f17_fbf8;
	int         cyc_cnt = 0;
	int         err_cnt = 0;
	int         tests_run = 0;
	int         tests_failed = 0;
	int         test_errs0 = 0;  // err_cnt when the current test began
	// checker state
	logic       scan_chk = 1'b0; // sample checks on
	logic [3:0] exp_char = 4'h0;
	int         chk_from = 0;    // compare only frames starting at or after this cycle
	int         done_from = 0;   // start cycle of the last compared frame
	logic       in_frame;
	logic       prev_mark;
	int         scan_pos;
	int         slot;
	int         low_idx;
	int         frame_start;
	glyph_t     lows;            // segments seen sinking this frame

	seg16_top dut (
		.CLK        (CLK),
		.reset      (reset),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.seg_n      (seg_n),
		.frame_mark (frame_mark)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK)
		cyc_cnt <= cyc_cnt + 1;

	// hex digit patterns with lit segments as ones
	function automatic glyph_t ref_glyph(input logic [3:0] code);
		glyph_t g;
		case (code)
			4'h0: g = SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F | SEG_G | SEG_H;
			4'h1: g = SEG_C | SEG_D;
			4'h2: g = SEG_A | SEG_B | SEG_C | SEG_E | SEG_F | SEG_G | SEG_U | SEG_P;
			4'h3: g = SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F | SEG_U | SEG_P;
			4'h4: g = SEG_C | SEG_D | SEG_H | SEG_U | SEG_P;
			4'h5: g = SEG_A | SEG_B | SEG_D | SEG_E | SEG_F | SEG_H | SEG_U | SEG_P;
			4'h6: g = SEG_A | SEG_B | SEG_D | SEG_E | SEG_F | SEG_G | SEG_H | SEG_U | SEG_P;
			4'h7: g = SEG_A | SEG_B | SEG_C | SEG_D;
			4'h8: g = SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F | SEG_G | SEG_H
				| SEG_U | SEG_P;
			4'h9: g = SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F | SEG_H | SEG_U | SEG_P;
			4'ha: g = SEG_A | SEG_B | SEG_C | SEG_D | SEG_G | SEG_H | SEG_U | SEG_P;
			4'hb: g = SEG_D | SEG_E | SEG_F | SEG_G | SEG_H | SEG_U | SEG_P;
			4'hc: g = SEG_A | SEG_B | SEG_E | SEG_F | SEG_G | SEG_H;
			4'hd: g = SEG_C | SEG_D | SEG_E | SEG_F | SEG_G | SEG_U | SEG_P;
			4'he: g = SEG_A | SEG_B | SEG_E | SEG_F | SEG_G | SEG_H | SEG_U;
			default: g = SEG_A | SEG_B | SEG_G | SEG_H | SEG_U; // F
		endcase
		return g;
	endfunction

	// lowest zero bit of the pin vector or -1 if dark
	function automatic int zero_position(input logic [15:0] v);
		int k;
		int at;
		at = -1;
		for (k = 15; k >= 0; k--)
			if (!v[k])
				at = k;
		return at;
	endfunction

	task automatic value_error(input string msg);
		$display("ERR %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic protocol_error(input string msg);
		$display("protocol failure at %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (err_cnt == test_errs0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, err_cnt - test_errs0);
		end
		test_errs0 = err_cnt;
	endtask

	// called and returning just after a falling edge
	task automatic write_reg(input logic [`SEG16_ADDR_W-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int hold;
		int i;
		hold    = $unsigned($random(seed)) % 5; // cycles of bready low
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge CLK);
		while (!(awready && wready))
			@(negedge CLK);
		@(negedge CLK); // aw and w taken on the edge just passed
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			@(negedge CLK);
		resp = bresp;
		for (i = 0; i < hold; i++) begin
			@(negedge CLK);
			assert (bvalid) else protocol_error("bvalid dropped while bready was low");
		end
		bready = 1'b1;
		@(negedge CLK);
		bready = 1'b0;
	endtask

	task automatic read_reg(input logic [`SEG16_ADDR_W-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int hold;
		int i;
		hold    = $unsigned($random(seed)) % 5;
		araddr  = addr;
		arvalid = 1'b1;
		@(negedge CLK);
		while (!arready)
			@(negedge CLK);
		@(negedge CLK);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge CLK);
		data = rdata;
		resp = rresp;
		for (i = 0; i < hold; i++) begin
			@(negedge CLK);
			assert (rvalid) else protocol_error("rvalid dropped while rready was low");
		end
		rready = 1'b1;
		@(negedge CLK);
		rready = 1'b0;
	endtask

	task automatic write_expect(input logic [`SEG16_ADDR_W-1:0] addr, input logic [31:0] data,
			input axil_resp_e want);
		logic [1:0] resp;
		write_reg(addr, data, resp);
		assert (resp == want)
			else value_error($sformatf("write to %0d: resp %0d, expected %0d", addr, resp, want));
	endtask

	// data is only meaningful on OKAY
	task automatic read_expect(input logic [`SEG16_ADDR_W-1:0] addr, input logic [31:0] want,
			input axil_resp_e want_resp, input string what);
		logic [31:0] data;
		logic [1:0]  resp;
		read_reg(addr, data, resp);
		assert (resp == want_resp)
			else value_error($sformatf("%s read: resp %0d, expected %0d", what, resp, want_resp));
		if (want_resp == RESP_OKAY)
			assert (data == want)
				else value_error($sformatf("%s read %h, expected %h", what, data, want));
	endtask

	// scan checker sampling the pins on the falling edge
	always @(negedge CLK) begin
		if (reset || !scan_chk) begin
			in_frame  = 1'b0;
			prev_mark = frame_mark; // a frame already under way is no rise
			scan_pos  = 0;
			lows      = '0;
		end else begin
			assert ($countones(~seg_n) <= 1)
				else value_error($sformatf("more than one segment sinking, seg_n %h", seg_n));
			if (frame_mark && !prev_mark) begin // new frame so the previous one is complete
				if (in_frame && scan_pos == FRAME_CYC && frame_start >= chk_from) begin
					assert (lows == ref_glyph(exp_char))
						else value_error($sformatf("char %h lit %h, expected %h",
							exp_char, lows, ref_glyph(exp_char)));
					done_from <= frame_start;
				end
				in_frame    = 1'b1;
				scan_pos    = 0;
				lows        = '0;
				frame_start = cyc_cnt;
			end
			if (in_frame) begin
				slot    = (scan_pos % FRAME_CYC) / SLOT_CYC;
				low_idx = zero_position(seg_n);
				assert (frame_mark == (slot == 0))
					else value_error($sformatf("frame_mark %b in slot %0d", frame_mark, slot));
				assert (low_idx < 0 || low_idx == 15 - slot)
					else value_error($sformatf("bit %0d low in slot %0d", low_idx, slot));
				lows     = lows | ~seg_n;
				scan_pos = scan_pos + 1;
			end
			prev_mark = frame_mark;
		end
	end

	initial begin
		while (cyc_cnt < TIMEOUT_CYC)
			@(negedge CLK);
		$display("timeout: run not finished after %0d cycles", TIMEOUT_CYC);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic [1:0]  resp;
		logic [1:0]  ctrl_v;
		logic [3:0]  char_v;
		logic [3:0]  prev;
		logic [3:0]  cur;
		logic [3:0]  nxt;
		int          from;
		int          steps;
		int          wraps;
		int          i;

		reset   = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '1;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (10) @(negedge CLK);
		reset = 1'b0;

		// reset state
		assert (seg_n == 16'hffff && !frame_mark)
			else value_error($sformatf("after reset seg_n %h frame_mark %b", seg_n, frame_mark));
		assert (!bvalid && !rvalid && !awready && !wready && !arready)
			else value_error("handshake outputs active after reset");
		read_expect(ADDR_CTRL, 32'h0, RESP_OKAY, "CTRL");
		read_expect(ADDR_CHAR, 32'h0, RESP_OKAY, "CHAR");
		read_expect(ADDR_STATUS, 32'h0, RESP_OKAY, "STATUS");
		close_test("reset state");

		// random register traffic with back-pressure
		for (i = 0; i < REG_ROUNDS; i++) begin
			ctrl_v = 2'($unsigned($random(seed)));
			char_v = 4'($unsigned($random(seed)));
			write_expect(ADDR_CTRL, {30'd0, ctrl_v}, RESP_OKAY);
			write_expect(ADDR_CHAR, {28'd0, char_v}, RESP_OKAY);
			read_expect(ADDR_CTRL, {30'd0, ctrl_v}, RESP_OKAY, "CTRL");
			read_expect(ADDR_CHAR, {28'd0, char_v}, RESP_OKAY, "CHAR");
			if (ctrl_v[1] == MODE_HOLD)
				read_expect(ADDR_STATUS, {28'd0, char_v}, RESP_OKAY, "STATUS");
		end
		close_test("register access");

		// count mode but stopped so nothing moves
		write_expect(ADDR_CTRL, 32'h2, RESP_OKAY);
		write_expect(ADDR_CHAR, 32'h9, RESP_OKAY);
		write_expect(ADDR_BAD, 32'hffff_ffff, RESP_SLVERR);
		write_expect(ADDR_STATUS, 32'h6, RESP_SLVERR);
		read_expect(ADDR_BAD, 32'h0, RESP_SLVERR, "unmapped");
		read_expect(ADDR_CTRL, 32'h2, RESP_OKAY, "CTRL");
		read_expect(ADDR_CHAR, 32'h9, RESP_OKAY, "CHAR");
		read_expect(ADDR_STATUS, 32'h9, RESP_OKAY, "STATUS");
		close_test("error responses");

		// every glyph in hold mode
		write_expect(ADDR_CTRL, 32'h1, RESP_OKAY);
		chk_from <= 32'h7fff_ffff;
		scan_chk <= 1'b1;
		for (i = 0; i < 16; i++) begin
			write_expect(ADDR_CHAR, 32'(i), RESP_OKAY);
			from = cyc_cnt + 2; // first frame drawn wholly from the new glyph
			exp_char <= 4'(i);
			chk_from <= from;
			while (done_from < from)
				@(negedge CLK);
		end
		close_test("glyph scan");

		// free-running count with sample checks left on
		chk_from <= 32'h7fff_ffff;
		write_expect(ADDR_CTRL, 32'h3, RESP_OKAY);
		read_reg(ADDR_STATUS, rd, resp);
		prev  = rd[3:0];
		steps = 0;
		wraps = 0;
		while (steps < COUNT_STEPS) begin
			read_reg(ADDR_STATUS, rd, resp);
			assert (resp == RESP_OKAY) else value_error("STATUS read not OKAY in count mode");
			cur = rd[3:0];
			nxt = prev + 4'h1;
			if (cur != prev) begin
				assert (cur == nxt)
					else value_error($sformatf("count went %h -> %h", prev, cur));
				if (prev == 4'hf && cur == 4'h0)
					wraps++;
				steps++;
				prev = cur;
			end
		end
		assert (wraps > 0) else protocol_error("count mode never wrapped from F to 0");
		close_test("count mode");

		// pins go dark on disable and stay dark
		scan_chk <= 1'b0;
		write_expect(ADDR_CTRL, 32'h0, RESP_OKAY);
		for (i = 0; i < 2 * FRAME_CYC; i++) begin
			assert (seg_n == 16'hffff && !frame_mark)
				else value_error($sformatf("disabled but seg_n %h frame_mark %b",
					seg_n, frame_mark));
			@(negedge CLK);
		end
		close_test("disable");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule : tb_seg16

`default_nettype wire

// File: src/seg16_top.sv
/* sixteen-segment controller top, AXI4-Lite register slave plus scan engine */
`timescale 1ns/1ps
`default_nettype none
`include "seg16_consts.svh"

module seg16_top (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic [`SEG16_ADDR_W-1:0]    awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [`SEG16_DATA_W-1:0]    wdata,
	input  logic [`SEG16_DATA_W/8-1:0]  wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [`SEG16_ADDR_W-1:0]    araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [`SEG16_DATA_W-1:0]    rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready,
	output logic [15:0]                 seg_n,      // a..r, active low
	output logic                        frame_mark  // scan at segment a
);

	disp_ctrl_if disp_bus (); // regs -> scanner control, scanner -> regs status

	seg16_axil_regs u_regs (
		.CLK     (CLK),
		.reset   (reset),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.ctrl    (disp_bus.ctrl)
	);

	seg16_scanner u_scan (
		.CLK        (CLK),
		.reset      (reset),
		.disp       (disp_bus.disp),
		.seg_n      (seg_n),
		.frame_mark (frame_mark)
	);

endmodule : seg16_top

`default_nettype wire

// File: seg16/seg16_scanner.sv
/* segment scan engine: slot divider, segment index, frame counter,
   character register with count-mode stepping, active-low drive */
`timescale 1ns/1ps
`default_nettype none
`include "seg16_consts.svh"

module seg16_scanner
	import seg16_pkg::*;
(
	input  logic        CLK,
	input  logic        reset,
	disp_ctrl_if.disp   disp,
	output logic [15:0] seg_n,      // active low, one segment at a time
	output logic        frame_mark  // high while slot a is driven
);

	localparam int DIV_W      = `SEG16_SCAN_DIV_BITS;
	localparam int LAST_FRAME = `SEG16_FRAMES_PER_STEP - 1;
	localparam int FRAME_W    = (`SEG16_FRAMES_PER_STEP > 1) ?
		$clog2(`SEG16_FRAMES_PER_STEP) : 1;

	logic [DIV_W-1:0]   div_cnt;   // clocks inside a slot
	logic [3:0]         seg_idx;   // 0 = a ... 15 = r
	logic [FRAME_W-1:0] frame_cnt; // frames since last step
	logic [3:0]         char_q;
	glyph_t             glyph;
	logic               slot_end;
	logic               frame_end;
	logic               step;      // count-mode increment
	logic [3:0]         slot_bit;  // glyph bit of the current slot
	logic [15:0]        drive_n;

	seg16_glyph_rom u_rom (
		.code  (char_q),
		.glyph (glyph)
	);

	assign slot_end  = &div_cnt;
	assign frame_end = slot_end && (seg_idx == 4'hf);
	assign step      = disp.enable && (disp.mode == MODE_COUNT) && frame_end &&
		(frame_cnt == FRAME_W'(LAST_FRAME));

	// timing chain, parked at zero while disabled
	always_ff @(posedge CLK) begin
		if (reset || !disp.enable) begin
			div_cnt   <= '0;
			seg_idx   <= 4'h0;
			frame_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			if (slot_end)
				seg_idx <= seg_idx + 4'h1; // wraps r -> a
			if (frame_end) begin
				if (frame_cnt == FRAME_W'(LAST_FRAME))
					frame_cnt <= '0;
				else
					frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// host write wins over a step on the same edge
	always_ff @(posedge CLK) begin
		if (reset)
			char_q <= 4'h0;
		else if (disp.load)
			char_q <= disp.char_code;
		else if (step)
			char_q <= char_q + 4'h1; // mod 16
	end

	assign disp.cur_char = char_q;

	// segment a sits in bit 15
	assign slot_bit = 4'd15 - seg_idx;

	always_comb begin
		drive_n           = '1;
		drive_n[slot_bit] = ~glyph[slot_bit]; // sink only if lit
	end

	// registered pins, marker stays aligned with the drive
	always_ff @(posedge CLK) begin
		if (reset || !disp.enable) begin
			seg_n      <= '1;
			frame_mark <= 1'b0;
		end else begin
			seg_n      <= drive_n;
			frame_mark <= (seg_idx == 4'h0);
		end
	end

	// common anode, never more than one segment sinking
	a_one_low: assert property (@(posedge CLK) disable iff (reset)
		$countones(~seg_n) <= 1);

endmodule : seg16_scanner

`default_nettype wire

// File: seg16/seg16_glyph_rom.sv
/* hex digit to sixteen-segment glyph, lit segments as ones */
`timescale 1ns/1ps
`default_nettype none

module seg16_glyph_rom
	import seg16_pkg::*;
(
	input  logic [3:0] code,
	output glyph_t     glyph
);

	// bit order a b c d e f g h k m n u p t s r, msb first
	// outer ring a..h in the top byte, inner bars in the low byte
	always_comb begin
		case (code)
			4'h0:    glyph = 16'hff00; // full ring
			4'h1:    glyph = 16'h3000; // c, d
			4'h2:    glyph = 16'hee18;
			4'h3:    glyph = 16'hfc18;
			4'h4:    glyph = 16'h3118;
			4'h5:    glyph = 16'hdd18;
			4'h6:    glyph = 16'hdf18;
			4'h7:    glyph = 16'hf000; // top and right side only
			4'h8:    glyph = 16'hff18; // ring plus middle bars
			4'h9:    glyph = 16'hfd18;
			4'ha:    glyph = 16'hf318;
			4'hb:    glyph = 16'h1f18;
			4'hc:    glyph = 16'hcf00;
			4'hd:    glyph = 16'h3e18;
			4'he:    glyph = 16'hcf10;
			default: glyph = 16'hc310; // F
		endcase
	end

endmodule : seg16_glyph_rom

`default_nettype wire

// File: src/seg16_axil_regs.sv
/* AXI4-Lite slave with CTRL, CHAR and read-only STATUS registers,
   driving the display control link */
`timescale 1ns/1ps
`default_nettype none
`include "seg16_consts.svh"

module seg16_axil_regs
	import seg16_pkg::*;
(
	input  logic                        CLK,
	input  logic                        reset,
	// write address / data
	input  logic [`SEG16_ADDR_W-1:0]    awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [`SEG16_DATA_W-1:0]    wdata,
	input  logic [`SEG16_DATA_W/8-1:0]  wstrb, // registers are narrow, strobes not needed
	input  logic                        wvalid,
	output logic                        wready,
	// write response
	output axil_resp_e                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	// read
	input  logic [`SEG16_ADDR_W-1:0]    araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [`SEG16_DATA_W-1:0]    rdata,
	output axil_resp_e                  rresp,
	output logic                        rvalid,
	input  logic                        rready,
	disp_ctrl_if.ctrl                   ctrl
);

	reg_sel_e                   wr_sel;
	reg_sel_e                   rd_sel;
	logic                       wr_fire;     // aw and w accepted this edge
	logic                       rd_fire;     // ar accepted this edge
	logic                       wr_ok;       // target is writable
	logic                       ctrl_enable;
	disp_mode_e                 ctrl_mode;
	logic [3:0]                 char_reg;
	logic                       load_q;
	logic [`SEG16_DATA_W-1:0]   rd_word;

	// byte address to register, anything else is unmapped
	function automatic reg_sel_e decode(input logic [`SEG16_ADDR_W-1:0] addr);
		case (addr)
			`SEG16_ADDR_W'(`SEG16_ADDR_CTRL):   return REG_CTRL;
			`SEG16_ADDR_W'(`SEG16_ADDR_CHAR):   return REG_CHAR;
			`SEG16_ADDR_W'(`SEG16_ADDR_STATUS): return REG_STATUS;
			default:                            return REG_NONE;
		endcase
	endfunction

	assign wr_sel  = decode(awaddr);
	assign rd_sel  = decode(araddr);
	assign wr_fire = awvalid && wvalid && awready && wready;
	assign rd_fire = arvalid && arready;
	assign wr_ok   = (wr_sel == REG_CTRL) || (wr_sel == REG_CHAR); // STATUS is read-only

	// write channel, aw and w taken together
	always_ff @(posedge CLK) begin
		if (reset) begin
			awready     <= 1'b0;
			wready      <= 1'b0;
			bvalid      <= 1'b0;
			ctrl_enable <= 1'b0;
			ctrl_mode   <= MODE_HOLD;
			char_reg    <= 4'h0;
			load_q      <= 1'b0;
		end else begin
			load_q <= 1'b0;
			// one-cycle ready, only while no response is waiting
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready  <= awvalid && wvalid && !awready && !bvalid;
			if (wr_fire) begin
				bvalid <= 1'b1;
				case (wr_sel)
					REG_CTRL: begin
						ctrl_enable <= wdata[0];
						ctrl_mode   <= disp_mode_e'(wdata[1]);
					end
					REG_CHAR: begin
						char_reg <= wdata[3:0];
						load_q   <= 1'b1; // scanner picks it up next edge
					end
					default: ; // slverr, nothing changes
				endcase
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_fire)
			bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
	end

	// read mux
	always_comb begin
		rd_word = '0;
		case (rd_sel)
			REG_CTRL:   rd_word[1:0] = {ctrl_mode, ctrl_enable};
			REG_CHAR:   rd_word[3:0] = char_reg;
			REG_STATUS: rd_word[3:0] = ctrl.cur_char; // live value, moves in count mode
			default:    ;
		endcase
	end

	// read channel, independent of writes
	always_ff @(posedge CLK) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (rd_fire) begin
			rdata <= rd_word;
			rresp <= (rd_sel == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
		end
	end

	assign ctrl.enable    = ctrl_enable;
	assign ctrl.mode      = ctrl_mode;
	assign ctrl.char_code = char_reg;
	assign ctrl.load      = load_q;

	// responses must wait for the master
	a_bvalid_hold: assert property (@(posedge CLK) disable iff (reset)
		bvalid && !bready |=> bvalid);
	a_rvalid_hold: assert property (@(posedge CLK) disable iff (reset)
		rvalid && !rready |=> rvalid);

endmodule : seg16_axil_regs

`default_nettype wire

// File: common/disp_ctrl_if.sv
/* control link between the register slave and the scan engine */
`timescale 1ns/1ps
`default_nettype none

interface disp_ctrl_if
	import seg16_pkg::*;
();

	logic       enable;    // scan running
	disp_mode_e mode;      // hold or count
	logic [3:0] char_code; // character written by the host
	logic       load;      // one-cycle pulse, char_code is new
	logic [3:0] cur_char;  // character on the display now

	// register side
	modport ctrl (
		output enable,
		output mode,
		output char_code,
		output load,
		input  cur_char
	);

	// scan engine side
	modport disp (
		input  enable,
		input  mode,
		input  char_code,
		input  load,
		output cur_char
	);

endinterface : disp_ctrl_if

`default_nettype wire

// File: common/seg16_pkg.sv
/* shared types for the sixteen-segment controller:
   display mode, register select, AXI response code and glyph vector */
`default_nettype none

package seg16_pkg;

	// display behaviour, one bit in CTRL[1]
	typedef enum logic {
		MODE_HOLD  = 1'b0, // show the written character
		MODE_COUNT = 1'b1  // step the character every few frames
	} disp_mode_e;

	// register addressed by an AXI access
	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,
		REG_CHAR   = 2'd1,
		REG_STATUS = 2'd2,
		REG_NONE   = 2'd3 // unmapped
	} reg_sel_e;

	// only the two codes this slave returns
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	// one bit per segment, 1 = lit
	// bit 15 is a, then b c d e f g h k m n u p t s, bit 0 is r
	typedef logic [15:0] glyph_t;

endpackage : seg16_pkg

`default_nettype wire

// File: common/seg16_consts.svh
/* bus widths, register map and scan timing constants */
`ifndef SEG16_CONSTS_SVH
`define SEG16_CONSTS_SVH

// AXI4-Lite widths
`define SEG16_ADDR_W 4
`define SEG16_DATA_W 32

// register byte addresses
`define SEG16_ADDR_CTRL   0
`define SEG16_ADDR_CHAR   4
`define SEG16_ADDR_STATUS 8

// clocks per segment slot = 2**n
// small for simulation, raise for a real display
`define SEG16_SCAN_DIV_BITS 3

// full frames between count-mode steps
`define SEG16_FRAMES_PER_STEP 4

`endif
